// File: common/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

typedef logic [31:0] vaddr_t;
typedef logic [31:0] paddr_t;
typedef logic [31:0] word_t;

// page cache attribute, same encoding as Config.K0
typedef logic [2:0] cattr_t;

localparam cattr_t CATTR_UNCACHED = 3'd2;
localparam cattr_t CATTR_UNCACHED_ACC = 3'd7;

function automatic logic is_uncached(cattr_t c);
	return (c == CATTR_UNCACHED) || (c == CATTR_UNCACHED_ACC);
endfunction

// where a translated access goes
typedef enum logic [1:0] {
	TGT_NONE,
	TGT_CACHE,
	TGT_MEM,
	TGT_PERIPH
} target_t;

typedef struct packed {
	logic addr_err;
	logic refill;
	logic invalid;
	logic modified;
} xlate_exc_t;

typedef struct packed {
	paddr_t     paddr;
	target_t    target;
	xlate_exc_t exc;
} xlate_res_t;

endpackage

`default_nettype wire

// File: common/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

// vaddr[31:13], one even/odd page pair
typedef logic [18:0] vpn2_t;
typedef logic [7:0] asid_t;
typedef logic [19:0] pfn_t;

// EntryLo layout, pfn in bits 25:6
typedef struct packed {
	logic            [5:0] zero;
	pfn_t            pfn;
	mmu_pkg::cattr_t c;
	logic            d;
	logic            v;
	logic            g;
} tlb_lo_t;

// EntryHi layout
typedef struct packed {
	vpn2_t      vpn2;
	logic [4:0] zero;
	asid_t      asid;
} tlb_hi_t;

typedef struct packed {
	logic            hit;
	mmu_pkg::paddr_t paddr;
	mmu_pkg::cattr_t c;
	logic            d;
	logic            v;
} tlb_hit_t;

endpackage

`default_nettype wire

// File: dv/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

localparam int N_STEPS = 240;

logic clk_i, rst_n_i;
logic [31:0] ivaddr_i, dvaddr_i;
logic instr_tlbp_i, instr_tlbr_i, instr_tlbwi_i, instr_tlbwr_i;
logic [31:0] cp0_entryhi_i, cp0_entrylo0_i, cp0_entrylo1_i, cp0_random_i;
logic [31:0] cp0_index_i, cp0_status_i, cp0_config_i;
logic dm_en_i, dm_wr_i, dm_unsigned_i;
logic [3:0] dm_bytesel_i;
logic [31:0] dm_data_i, icache_data_i, ibus_data_i, dcache_data_i, dbus_data_i, periph_data_i;
logic icache_ready_i, ibus_ready_i, dcache_ready_i, dbus_ready_i, periph_ready_i;
logic [31:0] iphy_addr_o, dphy_addr_o, data_o, instruction_o, dm_data_o, bad_vaddr_o;
logic icache_en_o, ibus_en_o, dcache_en_o, dbus_en_o, periph_en_o, data_wr_o, cpu_pause_o;
logic [3:0] data_bytesel_o, tlbp_index_o;
logic exc_addr_err_o, exc_refill_o, exc_invalid_o, exc_mod_o, exc_by_instr_o, exc_rw_o;
logic tlbp_hit_o, tlbr_valid_o;
logic [31:0] tlb_entryhi_o, tlb_entrylo0_o, tlb_entrylo1_o;

// shadow TLB for the reference model
logic sh_valid [16];
logic [18:0] sh_vpn2 [16];
logic [7:0] sh_asid [16];
logic sh_g [16];
logic [31:0] sh_lo0 [16];
logic [31:0] sh_lo1 [16];
logic [31:0] lfsr;
logic checking;
string test_name;
logic [3:0] wr_idx;
int s;
int s2;

mmu dut_i (.*);

initial
begin
	clk_i = 1'b0;
	forever #10 clk_i = ~clk_i;
end

initial
begin
	#(N_STEPS * 20 + 500);
	$display("watchdog expired before the tests finished");
	$display("Test FAILED");
	$fatal(1);
end

// taps 32, 22, 2, 1
function automatic logic [31:0] rnd(input int n);
	logic [31:0] r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

function automatic logic uncached(input logic [2:0] c);
	return (c == 3'd2) || (c == 3'd7);
endfunction

// packs {paddr, target, addr_err refill invalid modified}
// target codes 1 cache 2 mem 3 periph
function automatic logic [37:0] mmu_model(input logic [31:0] va, input logic is_data,
	input logic req, input logic wr);
	logic [31:0] pa;
	logic [1:0] tgt;
	logic [3:0] exc;
	logic [31:0] lo;
	logic hit;
	pa = '0;
	tgt = 2'd0;
	exc = 4'b0;
	lo = '0;
	hit = 1'b0;
	if (req)
	begin
		if (cp0_status_i[4] && !cp0_status_i[1] && va[31])
			exc = 4'b1000;
		else if (va[31:29] == 3'b100)
		begin
			pa = {3'b000, va[28:0]};
			tgt = uncached(cp0_config_i[2:0]) ? 2'd2 : 2'd1;
		end
		else if (va[31:29] == 3'b101)
		begin
			pa = {3'b000, va[28:0]};
			tgt = is_data ? 2'd3 : 2'd2;
		end
		else
		begin
			for (int i = 0; i < 16; i++)
				if (sh_valid[i] && sh_vpn2[i] == va[31:13]
					&& (sh_g[i] || sh_asid[i] == cp0_entryhi_i[7:0]))
				begin
					hit = 1'b1;
					lo = va[12] ? sh_lo1[i] : sh_lo0[i];
				end
			if (hit)
				pa = {lo[25:6], va[11:0]};
			if (!hit)
				exc = 4'b0100;
			else if (!lo[1])
				exc = 4'b0010;
			else if (is_data && wr && !lo[2])
				exc = 4'b0001;
			else
				tgt = uncached(lo[5:3]) ? 2'd2 : 2'd1;
		end
	end
	return {pa, tgt, exc};
endfunction

task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act)
	begin
		$display("MISMATCH test=%s signal=%s expected=%h actual=%h", test_name, sig, exp, act);
		$display("Test FAILED");
		$fatal(1);
	end
endtask

task automatic compare_outputs();
	logic [37:0] ir;
	logic [37:0] dr;
	logic [31:0] raw;
	logic [31:0] ld;
	logic iexc;
	logic dexc;
	logic phit;
	logic [3:0] pidx;
	ir = mmu_model(ivaddr_i, 1'b0, 1'b1, 1'b0);
	dr = mmu_model(dvaddr_i, 1'b1, dm_en_i, dm_wr_i);
	iexc = ir[3:0] != 4'b0;
	dexc = dr[3:0] != 4'b0;
	check_val("iphy_addr", ir[37:6], iphy_addr_o);
	check_val("dphy_addr", dr[37:6], dphy_addr_o);
	check_val("icache_en", 32'(ir[5:4] == 2'd1), 32'(icache_en_o));
	check_val("ibus_en", 32'(ir[5:4] == 2'd2), 32'(ibus_en_o));
	check_val("dcache_en", 32'(dr[5:4] == 2'd1), 32'(dcache_en_o));
	check_val("dbus_en", 32'(dr[5:4] == 2'd2), 32'(dbus_en_o));
	check_val("periph_en", 32'(dr[5:4] == 2'd3), 32'(periph_en_o));
	check_val("instruction", ir[5:4] == 2'd1 ? icache_data_i
		: (ir[5:4] == 2'd2 ? ibus_data_i : 32'h0), instruction_o);
	raw = dr[5:4] == 2'd1 ? dcache_data_i : dr[5:4] == 2'd2 ? dbus_data_i
		: dr[5:4] == 2'd3 ? periph_data_i : 32'h0;
	ld = raw;
	if (dm_bytesel_i == 4'b0001)
		ld = dm_unsigned_i ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
	else if (dm_bytesel_i == 4'b0011)
		ld = dm_unsigned_i ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
	check_val("dm_data", ld, dm_data_o);
	check_val("data", dm_data_i, data_o);
	check_val("data_wr", 32'(dm_wr_i), 32'(data_wr_o));
	check_val("data_bytesel", 32'(dm_bytesel_i), 32'(data_bytesel_o));
	check_val("exc_addr_err", 32'(ir[3] | dr[3]), 32'(exc_addr_err_o));
	check_val("exc_refill", 32'(ir[2] | dr[2]), 32'(exc_refill_o));
	check_val("exc_invalid", 32'(ir[1] | dr[1]), 32'(exc_invalid_o));
	check_val("exc_mod", 32'(dr[0]), 32'(exc_mod_o));
	check_val("exc_by_instr", 32'(iexc), 32'(exc_by_instr_o));
	check_val("exc_rw", 32'(!iexc && dm_wr_i), 32'(exc_rw_o));
	check_val("bad_vaddr", iexc ? ivaddr_i : dvaddr_i, bad_vaddr_o);
	check_val("cpu_pause", 32'((!iexc && !icache_ready_i && !ibus_ready_i)
		|| (dm_en_i && !dexc && !dcache_ready_i && !dbus_ready_i && !periph_ready_i)),
		32'(cpu_pause_o));
	check_val("tlbr_valid", 32'(instr_tlbr_i), 32'(tlbr_valid_o));
	phit = 1'b0;
	pidx = 4'h0;
	for (int i = 0; i < 16; i++)
		if (sh_valid[i] && sh_vpn2[i] == cp0_entryhi_i[31:13]
			&& (sh_g[i] || sh_asid[i] == cp0_entryhi_i[7:0]))
		begin
			phit = 1'b1;
			pidx = 4'(i);
		end
	check_val("tlbp_hit", 32'(phit && instr_tlbp_i), 32'(tlbp_hit_o));
	if (instr_tlbp_i && phit)
		check_val("tlbp_index", 32'(pidx), 32'(tlbp_index_o));
	if (instr_tlbr_i)
	begin
		pidx = cp0_index_i[3:0];
		check_val("tlbr_hi", {sh_vpn2[pidx], 5'b0, sh_asid[pidx]}, tlb_entryhi_o);
		check_val("tlbr_lo0", {sh_lo0[pidx][31:1], sh_g[pidx]}, tlb_entrylo0_o);
		check_val("tlbr_lo1", {sh_lo1[pidx][31:1], sh_g[pidx]}, tlb_entrylo1_o);
	end
endtask

// compare well after the falling edge, before the next rising edge
initial
begin
	forever
	begin
		@(negedge clk_i);
		#8;
		if (checking)
			compare_outputs();
	end
end

// follow TLB writes on the edge where the DUT takes them
initial
begin
	forever
	begin
		@(posedge clk_i);
		if (rst_n_i && (instr_tlbwi_i || instr_tlbwr_i))
		begin
			wr_idx = instr_tlbwi_i ? cp0_index_i[3:0] : cp0_random_i[3:0];
			sh_valid[wr_idx] = 1'b1;
			sh_vpn2[wr_idx] = cp0_entryhi_i[31:13];
			sh_asid[wr_idx] = cp0_entryhi_i[7:0];
			sh_g[wr_idx] = cp0_entrylo0_i[0] & cp0_entrylo1_i[0];
			sh_lo0[wr_idx] = cp0_entrylo0_i;
			sh_lo1[wr_idx] = cp0_entrylo1_i;
		end
	end
end

task automatic begin_cycle();
	logic [1:0] b;
	@(negedge clk_i);
	{instr_tlbp_i, instr_tlbr_i, instr_tlbwi_i, instr_tlbwr_i} = 4'b0;
	icache_data_i = rnd(32);
	ibus_data_i = rnd(32);
	dcache_data_i = rnd(32);
	dbus_data_i = rnd(32);
	periph_data_i = rnd(32);
	dm_data_i = rnd(32);
	{icache_ready_i, ibus_ready_i, dcache_ready_i, dbus_ready_i, periph_ready_i} = 5'(rnd(5));
	b = 2'(rnd(2));
	dm_bytesel_i = b == 2'd0 ? 4'b0001 : (b == 2'd1 ? 4'b0011 : 4'b1111);
	dm_unsigned_i = 1'(rnd(1));
endtask

// slot number in the low vpn2 bits keeps live entries apart
task automatic write_entry(input int slot, input logic use_random, input logic [1:0] v,
	input logic [1:0] d);
	begin_cycle();
	cp0_entryhi_i = {1'b0, 14'(rnd(14)), 4'(slot), 5'b0, 8'(rnd(8))};
	cp0_entrylo0_i = {6'b0, 20'(rnd(20)), 3'(rnd(3)), d[0], v[0], 1'(rnd(1))};
	cp0_entrylo1_i = {6'b0, 20'(rnd(20)), 3'(rnd(3)), d[1], v[1], 1'(rnd(1))};
	if (use_random)
	begin
		// Index points at another slot so only Random can steer the write
		cp0_index_i = 32'(slot ^ 1);
		cp0_random_i = 32'(slot);
		instr_tlbwr_i = 1'b1;
	end
	else
	begin
		cp0_index_i = 32'(slot);
		instr_tlbwi_i = 1'b1;
	end
endtask

initial
begin
	lfsr = 32'hd25d_fd9f;
	checking = 1'b0;
	test_name = "reset";
	for (int i = 0; i < 16; i++)
		sh_valid[i] = 1'b0;
	rst_n_i = 1'b0;
	{ivaddr_i, dvaddr_i, cp0_entryhi_i, cp0_entrylo0_i, cp0_entrylo1_i} = '0;
	{cp0_random_i, cp0_index_i, cp0_status_i, cp0_config_i} = '0;
	{instr_tlbp_i, instr_tlbr_i, instr_tlbwi_i, instr_tlbwr_i} = 4'b0;
	{dm_en_i, dm_wr_i, dm_unsigned_i, dm_bytesel_i, dm_data_i} = '0;
	{icache_data_i, ibus_data_i, dcache_data_i, dbus_data_i, periph_data_i} = '0;
	{icache_ready_i, ibus_ready_i, dcache_ready_i, dbus_ready_i, periph_ready_i} = 5'b0;
	repeat (2) @(posedge clk_i);
	@(negedge clk_i);
	rst_n_i = 1'b1;
	checking = 1'b1;

	test_name = "unmapped";
	repeat (40)
	begin
		begin_cycle();
		cp0_config_i = {29'b0, 3'(rnd(3))};
		ivaddr_i = {2'b10, 30'(rnd(30))};
		dvaddr_i = {2'b10, 30'(rnd(30))};
		dm_en_i = 1'b1;
		dm_wr_i = 1'(rnd(1));
	end

	test_name = "mapped";
	for (int i = 0; i < 16; i++)
		write_entry(i, 1'b0, 2'b11, 2'(rnd(2)));
	repeat (40)
	begin
		begin_cycle();
		s = int'(rnd(4));
		s2 = int'(rnd(4));
		cp0_entryhi_i[7:0] = rnd(1) != 0 ? sh_asid[s] : 8'(rnd(8));
		ivaddr_i = {sh_vpn2[s], 13'(rnd(13))};
		dvaddr_i = {sh_vpn2[s2], 13'(rnd(13))};
		dm_wr_i = 1'(rnd(1));
	end

	test_name = "exceptions";
	write_entry(3, 1'b0, 2'b10, 2'b01);
	begin_cycle();
	ivaddr_i = 32'h8000_1000;
	dvaddr_i = {3'b110, 29'(rnd(29))};
	dm_wr_i = 1'b0;
	begin_cycle();
	cp0_entryhi_i[7:0] = sh_asid[3];
	dvaddr_i = {sh_vpn2[3], 1'b0, 12'(rnd(12))};
	begin_cycle();
	dvaddr_i = {sh_vpn2[3], 1'b1, 12'(rnd(12))};
	dm_wr_i = 1'b1;
	begin_cycle();
	cp0_status_i = 32'h10;
	ivaddr_i = {sh_vpn2[3], 1'b1, 12'h0};
	dvaddr_i = 32'h9000_0040;
	begin_cycle();
	ivaddr_i = 32'h8000_2000;
	begin_cycle();
	cp0_status_i = 32'h12;
	begin_cycle();
	cp0_status_i = 32'h0;
	ivaddr_i = 32'hc000_0100;
	dvaddr_i = {sh_vpn2[3], 1'b1, 12'h8};

	test_name = "probe_read";
	repeat (8)
	begin
		s = int'(rnd(4));
		begin_cycle();
		cp0_entryhi_i = {sh_vpn2[s], 5'b0, sh_asid[s]};
		instr_tlbp_i = 1'b1;
		begin_cycle();
		cp0_index_i = 32'(s);
		instr_tlbr_i = 1'b1;
		write_entry(s, 1'b1, 2'(rnd(2)), 2'(rnd(2)));
		begin_cycle();
		cp0_index_i = 32'(s);
		instr_tlbr_i = 1'b1;
	end
	begin_cycle();
	cp0_entryhi_i = 32'hc000_0000;
	instr_tlbp_i = 1'b1;

	test_name = "load_pause";
	repeat (70)
	begin
		begin_cycle();
		s = int'(rnd(4));
		cp0_status_i = rnd(2) == 0 ? 32'h10 : 32'h0;
		cp0_config_i = {29'b0, 3'(rnd(3))};
		ivaddr_i = rnd(1) != 0 ? {3'b100, 29'(rnd(29))} : {sh_vpn2[s], 13'(rnd(13))};
		case (2'(rnd(2)))
			2'd0: dvaddr_i = {3'b100, 29'(rnd(29))};
			2'd1: dvaddr_i = {3'b101, 29'(rnd(29))};
			2'd2: dvaddr_i = {sh_vpn2[s], 13'(rnd(13))};
			default: dvaddr_i = {3'b111, 29'(rnd(29))};
		endcase
		dm_en_i = 1'(rnd(1));
		dm_wr_i = 1'(rnd(1));
	end

	@(negedge clk_i);
	#10;
	$display("Test OK");
	$finish;
end

endmodule

`default_nettype wire

// File: hw/addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_xlate #(
	parameter bit IS_DATA = 1'b0
) (
	input  mmu_pkg::vaddr_t     vaddr_i,
	input  logic                req_i,
	input  logic                wr_i,
	input  logic                user_mode_i,
	input  mmu_pkg::cattr_t     k0_i,
	input  tlb_pkg::tlb_hit_t   tlb_i,
	output mmu_pkg::xlate_res_t res_o
);

always_comb
begin
	res_o = '0;
	if (req_i)
	begin
		if (user_mode_i && vaddr_i[31])
			res_o.exc.addr_err = 1'b1;
		else
		begin
			case (vaddr_i[31:29])
				// kseg0 is unmapped with the K0 attribute
				3'b100:
				begin
					res_o.paddr = {3'b000, vaddr_i[28:0]};
					res_o.target = mmu_pkg::is_uncached(k0_i) ? mmu_pkg::TGT_MEM
						: mmu_pkg::TGT_CACHE;
				end
				// kseg1 is unmapped and uncached
				3'b101:
				begin
					res_o.paddr = {3'b000, vaddr_i[28:0]};
					res_o.target = IS_DATA ? mmu_pkg::TGT_PERIPH : mmu_pkg::TGT_MEM;
				end
				default:
				begin
					res_o.paddr = tlb_i.paddr;
					if (!tlb_i.hit)
						res_o.exc.refill = 1'b1;
					else if (!tlb_i.v)
						res_o.exc.invalid = 1'b1;
					else if (IS_DATA && wr_i && !tlb_i.d)
						res_o.exc.modified = 1'b1;
					else
						res_o.target = mmu_pkg::is_uncached(tlb_i.c) ? mmu_pkg::TGT_MEM
							: mmu_pkg::TGT_CACHE;
				end
			endcase
		end
	end
end

// a TLB miss carries no page fields into a refill
always_comb
begin
	a_miss_empty: assert ($isunknown(tlb_i) || tlb_i.hit || (tlb_i == '0))
		else $error("addr_xlate: TLB miss with page fields set");
end

endmodule

`default_nettype wire

// File: hw/mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mmu #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  mmu_pkg::vaddr_t                ivaddr_i,
	input  mmu_pkg::vaddr_t                dvaddr_i,
	input  logic                           instr_tlbp_i,
	input  logic                           instr_tlbr_i,
	input  logic                           instr_tlbwi_i,
	input  logic                           instr_tlbwr_i,
	input  mmu_pkg::word_t                 cp0_entryhi_i,
	input  mmu_pkg::word_t                 cp0_entrylo0_i,
	input  mmu_pkg::word_t                 cp0_entrylo1_i,
	input  mmu_pkg::word_t                 cp0_random_i,
	input  mmu_pkg::word_t                 cp0_index_i,
	input  mmu_pkg::word_t                 cp0_status_i,
	input  mmu_pkg::word_t                 cp0_config_i,
	input  logic                           dm_en_i,
	input  logic                           dm_wr_i,
	input  logic [3:0]                     dm_bytesel_i,
	input  logic                           dm_unsigned_i,
	input  mmu_pkg::word_t                 dm_data_i,
	input  mmu_pkg::word_t                 icache_data_i,
	input  logic                           icache_ready_i,
	input  mmu_pkg::word_t                 ibus_data_i,
	input  logic                           ibus_ready_i,
	input  mmu_pkg::word_t                 dcache_data_i,
	input  logic                           dcache_ready_i,
	input  mmu_pkg::word_t                 dbus_data_i,
	input  logic                           dbus_ready_i,
	input  mmu_pkg::word_t                 periph_data_i,
	input  logic                           periph_ready_i,
	output mmu_pkg::paddr_t                iphy_addr_o,
	output mmu_pkg::paddr_t                dphy_addr_o,
	output logic                           icache_en_o,
	output logic                           ibus_en_o,
	output logic                           dcache_en_o,
	output logic                           dbus_en_o,
	output logic                           periph_en_o,
	output mmu_pkg::word_t                 data_o,
	output logic                           data_wr_o,
	output logic [3:0]                     data_bytesel_o,
	output mmu_pkg::word_t                 instruction_o,
	output mmu_pkg::word_t                 dm_data_o,
	output logic                           cpu_pause_o,
	output logic                           exc_addr_err_o,
	output logic                           exc_refill_o,
	output logic                           exc_invalid_o,
	output logic                           exc_mod_o,
	output logic                           exc_by_instr_o,
	output logic                           exc_rw_o,
	output mmu_pkg::vaddr_t                bad_vaddr_o,
	output logic                           tlbp_hit_o,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlbp_index_o,
	output mmu_pkg::word_t                 tlb_entryhi_o,
	output mmu_pkg::word_t                 tlb_entrylo0_o,
	output mmu_pkg::word_t                 tlb_entrylo1_o,
	output logic                           tlbr_valid_o
);

tlb_pkg::tlb_hi_t entryhi;
logic user_mode;
logic tlb_we;
logic [$clog2(TLB_ENTRIES)-1:0] tlb_index;
logic probe_hit;
tlb_pkg::tlb_hit_t ihit;
tlb_pkg::tlb_hit_t dhit;
mmu_pkg::xlate_res_t ires;
mmu_pkg::xlate_res_t dres;

assign entryhi = cp0_entryhi_i;
// Status.UM with EXL clear
assign user_mode = cp0_status_i[4] && !cp0_status_i[1];
assign tlbp_hit_o = probe_hit && instr_tlbp_i;

assign data_o = dm_data_i;
assign data_wr_o = dm_wr_i;
assign data_bytesel_o = dm_bytesel_i;

tlb_cmd #(.TLB_ENTRIES(TLB_ENTRIES)) cmd_i (
	.instr_tlbr_i, .instr_tlbwi_i, .instr_tlbwr_i, .cp0_index_i, .cp0_random_i,
	.tlb_we_o(tlb_we), .tlb_index_o(tlb_index), .tlbr_valid_o
);

jtlb #(.TLB_ENTRIES(TLB_ENTRIES)) jtlb_i (
	.clk_i, .rst_n_i, .we_i(tlb_we), .index_i(tlb_index), .hi_i(entryhi),
	.lo0_i(cp0_entrylo0_i), .lo1_i(cp0_entrylo1_i), .ivaddr_i, .dvaddr_i,
	.asid_i(entryhi.asid), .ihit_o(ihit), .dhit_o(dhit), .probe_hit_o(probe_hit),
	.probe_index_o(tlbp_index_o), .rd_hi_o(tlb_entryhi_o), .rd_lo0_o(tlb_entrylo0_o),
	.rd_lo1_o(tlb_entrylo1_o)
);

addr_xlate #(.IS_DATA(1'b0)) ixlate_i (
	.vaddr_i(ivaddr_i), .req_i(1'b1), .wr_i(1'b0), .user_mode_i(user_mode),
	.k0_i(cp0_config_i[2:0]), .tlb_i(ihit), .res_o(ires)
);

addr_xlate #(.IS_DATA(1'b1)) dxlate_i (
	.vaddr_i(dvaddr_i), .req_i(dm_en_i), .wr_i(dm_wr_i), .user_mode_i(user_mode),
	.k0_i(cp0_config_i[2:0]), .tlb_i(dhit), .res_o(dres)
);

mmu_resp resp_i (
	.ires_i(ires), .dres_i(dres), .icache_data_i, .icache_ready_i, .ibus_data_i,
	.ibus_ready_i, .dcache_data_i, .dcache_ready_i, .dbus_data_i, .dbus_ready_i,
	.periph_data_i, .periph_ready_i, .dm_en_i, .dm_wr_i, .dm_bytesel_i, .dm_unsigned_i,
	.ivaddr_i, .dvaddr_i, .icache_en_o, .ibus_en_o, .dcache_en_o, .dbus_en_o,
	.periph_en_o, .iphy_addr_o, .dphy_addr_o, .instruction_o, .dm_data_o,
	.exc_addr_err_o, .exc_refill_o, .exc_invalid_o, .exc_mod_o, .exc_by_instr_o,
	.exc_rw_o, .bad_vaddr_o, .cpu_pause_o
);

endmodule

`default_nettype wire

// File: hw/mmu_resp.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_resp (
	input  mmu_pkg::xlate_res_t ires_i,
	input  mmu_pkg::xlate_res_t dres_i,
	input  mmu_pkg::word_t      icache_data_i,
	input  logic                icache_ready_i,
	input  mmu_pkg::word_t      ibus_data_i,
	input  logic                ibus_ready_i,
	input  mmu_pkg::word_t      dcache_data_i,
	input  logic                dcache_ready_i,
	input  mmu_pkg::word_t      dbus_data_i,
	input  logic                dbus_ready_i,
	input  mmu_pkg::word_t      periph_data_i,
	input  logic                periph_ready_i,
	input  logic                dm_en_i,
	input  logic                dm_wr_i,
	input  logic [3:0]          dm_bytesel_i,
	input  logic                dm_unsigned_i,
	input  mmu_pkg::vaddr_t     ivaddr_i,
	input  mmu_pkg::vaddr_t     dvaddr_i,
	output logic                icache_en_o,
	output logic                ibus_en_o,
	output logic                dcache_en_o,
	output logic                dbus_en_o,
	output logic                periph_en_o,
	output mmu_pkg::paddr_t     iphy_addr_o,
	output mmu_pkg::paddr_t     dphy_addr_o,
	output mmu_pkg::word_t      instruction_o,
	output mmu_pkg::word_t      dm_data_o,
	output logic                exc_addr_err_o,
	output logic                exc_refill_o,
	output logic                exc_invalid_o,
	output logic                exc_mod_o,
	output logic                exc_by_instr_o,
	output logic                exc_rw_o,
	output mmu_pkg::vaddr_t     bad_vaddr_o,
	output logic                cpu_pause_o
);

logic iexc;
logic dexc;
mmu_pkg::word_t draw;

assign icache_en_o = ires_i.target == mmu_pkg::TGT_CACHE;
assign ibus_en_o = ires_i.target == mmu_pkg::TGT_MEM;
assign dcache_en_o = dres_i.target == mmu_pkg::TGT_CACHE;
assign dbus_en_o = dres_i.target == mmu_pkg::TGT_MEM;
assign periph_en_o = dres_i.target == mmu_pkg::TGT_PERIPH;
assign iphy_addr_o = ires_i.paddr;
assign dphy_addr_o = dres_i.paddr;

always_comb
begin
	case (ires_i.target)
		mmu_pkg::TGT_CACHE: instruction_o = icache_data_i;
		mmu_pkg::TGT_MEM: instruction_o = ibus_data_i;
		default: instruction_o = '0;
	endcase
	case (dres_i.target)
		mmu_pkg::TGT_CACHE: draw = dcache_data_i;
		mmu_pkg::TGT_MEM: draw = dbus_data_i;
		mmu_pkg::TGT_PERIPH: draw = periph_data_i;
		default: draw = '0;
	endcase
	// narrow loads come back in the low lanes
	case (dm_bytesel_i)
		4'b0001: dm_data_o = dm_unsigned_i ? {24'b0, draw[7:0]} : {{24{draw[7]}}, draw[7:0]};
		4'b0011: dm_data_o = dm_unsigned_i ? {16'b0, draw[15:0]}
			: {{16{draw[15]}}, draw[15:0]};
		default: dm_data_o = draw;
	endcase
end

assign iexc = ires_i.exc != '0;
assign dexc = dres_i.exc != '0;

assign exc_addr_err_o = ires_i.exc.addr_err || dres_i.exc.addr_err;
assign exc_refill_o = ires_i.exc.refill || dres_i.exc.refill;
assign exc_invalid_o = ires_i.exc.invalid || dres_i.exc.invalid;
assign exc_mod_o = dres_i.exc.modified;
// instruction side wins
assign exc_by_instr_o = iexc;
assign exc_rw_o = iexc ? 1'b0 : dm_wr_i;
assign bad_vaddr_o = iexc ? ivaddr_i : dvaddr_i;

assign cpu_pause_o = (!iexc && !icache_ready_i && !ibus_ready_i)
	|| (dm_en_i && !dexc && !dcache_ready_i && !dbus_ready_i && !periph_ready_i);

endmodule

`default_nettype wire

// File: hw/tlb_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_cmd #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                           instr_tlbr_i,
	input  logic                           instr_tlbwi_i,
	input  logic                           instr_tlbwr_i,
	input  mmu_pkg::word_t                 cp0_index_i,
	input  mmu_pkg::word_t                 cp0_random_i,
	output logic                           tlb_we_o,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlb_index_o,
	output logic                           tlbr_valid_o
);

localparam int IDX_W = $clog2(TLB_ENTRIES);

logic use_index;

// tlbr and tlbwi address the Index slot, tlbwr the Random slot
assign use_index = instr_tlbr_i || instr_tlbwi_i;
assign tlb_index_o = use_index ? cp0_index_i[IDX_W-1:0] : cp0_random_i[IDX_W-1:0];

assign tlb_we_o = instr_tlbwi_i || instr_tlbwr_i;
assign tlbr_valid_o = instr_tlbr_i;

// the core issues one TLB instruction at a time
always_comb
begin
	a_one_cmd: assert ($isunknown({instr_tlbr_i, instr_tlbwi_i, instr_tlbwr_i})
		|| $onehot0({instr_tlbr_i, instr_tlbwi_i, instr_tlbwr_i}))
		else $error("tlb_cmd: overlapping TLB instructions");
end

endmodule

`default_nettype wire

// File: jtlb/jtlb.sv
`timescale 1ns/1ps
`default_nettype none

module jtlb #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           we_i,
	input  logic [$clog2(TLB_ENTRIES)-1:0] index_i,
	input  tlb_pkg::tlb_hi_t               hi_i,
	input  tlb_pkg::tlb_lo_t               lo0_i,
	input  tlb_pkg::tlb_lo_t               lo1_i,
	input  mmu_pkg::vaddr_t                ivaddr_i,
	input  mmu_pkg::vaddr_t                dvaddr_i,
	input  tlb_pkg::asid_t                 asid_i,
	output tlb_pkg::tlb_hit_t              ihit_o,
	output tlb_pkg::tlb_hit_t              dhit_o,
	output logic                           probe_hit_o,
	output logic [$clog2(TLB_ENTRIES)-1:0] probe_index_o,
	output tlb_pkg::tlb_hi_t               rd_hi_o,
	output tlb_pkg::tlb_lo_t               rd_lo0_o,
	output tlb_pkg::tlb_lo_t               rd_lo1_o
);

localparam int IDX_W = $clog2(TLB_ENTRIES);

logic [TLB_ENTRIES-1:0] valid_q;
tlb_pkg::vpn2_t vpn2_q [TLB_ENTRIES];
tlb_pkg::asid_t asid_q [TLB_ENTRIES];
logic g_q [TLB_ENTRIES];
tlb_pkg::tlb_lo_t lo0_q [TLB_ENTRIES];
tlb_pkg::tlb_lo_t lo1_q [TLB_ENTRIES];
logic [TLB_ENTRIES-1:0] imatch;
logic [TLB_ENTRIES-1:0] dmatch;
logic [TLB_ENTRIES-1:0] pmatch;

always_ff @(posedge clk_i or negedge rst_n_i)
begin
	if (!rst_n_i)
		valid_q <= '0;
	else if (we_i)
		valid_q[index_i] <= 1'b1;
end

always_ff @(posedge clk_i)
begin
	if (we_i)
	begin
		vpn2_q[index_i] <= hi_i.vpn2;
		asid_q[index_i] <= hi_i.asid;
		// global only when both halves say so
		g_q[index_i] <= lo0_i.g & lo1_i.g;
		lo0_q[index_i] <= lo0_i;
		lo1_q[index_i] <= lo1_i;
	end
end

function automatic tlb_pkg::tlb_hit_t pick(mmu_pkg::vaddr_t va, logic [TLB_ENTRIES-1:0] m);
	tlb_pkg::tlb_hit_t r;
	tlb_pkg::tlb_lo_t lo;
	r = '0;
	for (int i = 0; i < TLB_ENTRIES; i++)
	begin
		if (m[i])
		begin
			// bit 12 selects the odd page
			lo = va[12] ? lo1_q[i] : lo0_q[i];
			r.hit = 1'b1;
			r.paddr = {lo.pfn, va[11:0]};
			r.c = lo.c;
			r.d = lo.d;
			r.v = lo.v;
		end
	end
	return r;
endfunction

// instruction, data and probe compares in parallel
always_comb
begin
	for (int i = 0; i < TLB_ENTRIES; i++)
	begin
		imatch[i] = valid_q[i] && (vpn2_q[i] == ivaddr_i[31:13])
			&& (g_q[i] || (asid_q[i] == asid_i));
		dmatch[i] = valid_q[i] && (vpn2_q[i] == dvaddr_i[31:13])
			&& (g_q[i] || (asid_q[i] == asid_i));
		pmatch[i] = valid_q[i] && (vpn2_q[i] == hi_i.vpn2)
			&& (g_q[i] || (asid_q[i] == hi_i.asid));
	end
end

always_comb
begin
	ihit_o = pick(ivaddr_i, imatch);
	dhit_o = pick(dvaddr_i, dmatch);
end

always_comb
begin
	probe_hit_o = 1'b0;
	probe_index_o = '0;
	for (int i = 0; i < TLB_ENTRIES; i++)
	begin
		if (pmatch[i])
		begin
			probe_hit_o = 1'b1;
			probe_index_o = IDX_W'(i);
		end
	end
end

// tlbr view of the indexed slot
always_comb
begin
	rd_hi_o.vpn2 = vpn2_q[index_i];
	rd_hi_o.zero = '0;
	rd_hi_o.asid = asid_q[index_i];
	rd_lo0_o = lo0_q[index_i];
	rd_lo0_o.g = g_q[index_i];
	rd_lo1_o = lo1_q[index_i];
	rd_lo1_o.g = g_q[index_i];
end

// writes never leave two live entries on the same page pair
a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	$onehot0(imatch) && $onehot0(dmatch) && $onehot0(pmatch))
	else $error("jtlb: more than one entry matches");

endmodule

`default_nettype wire

// File: mmu.f
common/mmu_pkg.sv
common/tlb_pkg.sv
jtlb/jtlb.sv
hw/tlb_cmd.sv
hw/addr_xlate.sv
hw/mmu_resp.sv
hw/mmu.sv
dv/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mmu_tb -f mmu.f -o Vmmu_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vmmu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
